// File: source/rv_ex_defines.svh
`ifndef RV_EX_DEFINES_SVH
`define RV_EX_DEFINES_SVH

// data and address width
`define RV_XLEN 64

// instruction width
`define RV_ILEN 32

// register file address width
`define RV_REG_AW 5

// byte lanes in one double word
`define RV_STRB_W 8

// shift amount widths, full and word
`define RV_SHAMT_W 6
`define RV_WSHAMT_W 5

// return address offset for jal/jalr
`define RV_LINK_OFS 4

`endif

// File: source/rv_ex_pkg.sv
package rv_ex_pkg;

    // alu operation, zero is a plain add
    typedef enum logic [3:0] {
        add    = 4'd0,
        sub    = 4'd1,
        sll    = 4'd2,
        slt    = 4'd3,
        sltu   = 4'd4,
        xor_op = 4'd5,
        srl    = 4'd6,
        sra    = 4'd7,
        or_op  = 4'd8,
        and_op = 4'd9
    } alu_op_e;

    // operand 1 source
    typedef enum logic [1:0] {
        src1_rs1  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    // operand 2 source
    typedef enum logic [2:0] {
        src2_rs2   = 3'd0,
        src2_imm_i = 3'd1,
        src2_imm_u = 3'd2,
        src2_shamt = 3'd3,
        src2_four  = 3'd4,
        src2_imm_s = 3'd5
    } src2_sel_e;

    // branch unit operation, bru_none means no redirect
    typedef enum logic [3:0] {
        bru_none = 4'd0,
        jal      = 4'd1,
        jalr     = 4'd2,
        beq      = 4'd3,
        bne      = 4'd4,
        blt      = 4'd5,
        bge      = 4'd6,
        bltu     = 4'd7,
        bgeu     = 4'd8
    } bru_op_e;

    // memory access size
    typedef enum logic [2:0] {
        lsu_none = 3'd0,
        lsu_b    = 3'd1,
        lsu_h    = 3'd2,
        lsu_w    = 3'd3,
        lsu_d    = 3'd4
    } lsu_size_e;

endpackage

// File: source/ex_stage_reg.sv
`timescale 1ns/1ps
`include "rv_ex_defines.svh"

module ex_stage_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic [`RV_XLEN-1:0]     pc_i,
    input  logic [`RV_XLEN-1:0]     next_pc_i,
    input  logic [`RV_ILEN-1:0]     inst_i,
    input  rv_ex_pkg::alu_op_e      alu_op_i,
    input  logic                    word_op_i,
    input  rv_ex_pkg::src1_sel_e    src1_sel_i,
    input  rv_ex_pkg::src2_sel_e    src2_sel_i,
    input  rv_ex_pkg::bru_op_e      bru_op_i,
    input  rv_ex_pkg::lsu_size_e    lsu_size_i,
    input  logic                    dmem_en_i,
    input  logic                    dmem_we_i,
    input  logic                    rf_we_i,
    input  logic [`RV_REG_AW-1:0]   rf_waddr_i,
    input  logic                    wb_from_mem_i,
    input  logic [`RV_XLEN-1:0]     rs1_data_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    output logic [`RV_XLEN-1:0]     pc_o,
    output logic [`RV_XLEN-1:0]     next_pc_o,
    output logic [`RV_ILEN-1:0]     inst_o,
    output rv_ex_pkg::alu_op_e      alu_op_o,
    output logic                    word_op_o,
    output rv_ex_pkg::src1_sel_e    src1_sel_o,
    output rv_ex_pkg::src2_sel_e    src2_sel_o,
    output rv_ex_pkg::bru_op_e      bru_op_o,
    output rv_ex_pkg::lsu_size_e    lsu_size_o,
    output logic                    dmem_en_o,
    output logic                    dmem_we_o,
    output logic                    rf_we_o,
    output logic [`RV_REG_AW-1:0]   rf_waddr_o,
    output logic                    wb_from_mem_o,
    output logic [`RV_XLEN-1:0]     rs1_data_o,
    output logic [`RV_XLEN-1:0]     rs2_data_o
);

    logic rf_we_q;

    // flush wins over stall, cleared state is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            pc_o          <= '0;
            next_pc_o     <= '0;
            inst_o        <= '0;
            alu_op_o      <= rv_ex_pkg::add;
            word_op_o     <= 1'b0;
            src1_sel_o    <= rv_ex_pkg::src1_rs1;
            src2_sel_o    <= rv_ex_pkg::src2_rs2;
            bru_op_o      <= rv_ex_pkg::bru_none;
            lsu_size_o    <= rv_ex_pkg::lsu_none;
            dmem_en_o     <= 1'b0;
            dmem_we_o     <= 1'b0;
            rf_we_q       <= 1'b0;
            rf_waddr_o    <= '0;
            wb_from_mem_o <= 1'b0;
            rs1_data_o    <= '0;
            rs2_data_o    <= '0;
        end else if (!stall_i) begin
            pc_o          <= pc_i;
            next_pc_o     <= next_pc_i;
            inst_o        <= inst_i;
            alu_op_o      <= alu_op_i;
            word_op_o     <= word_op_i;
            src1_sel_o    <= src1_sel_i;
            src2_sel_o    <= src2_sel_i;
            bru_op_o      <= bru_op_i;
            lsu_size_o    <= lsu_size_i;
            dmem_en_o     <= dmem_en_i;
            dmem_we_o     <= dmem_we_i;
            rf_we_q       <= rf_we_i;
            rf_waddr_o    <= rf_waddr_i;
            wb_from_mem_o <= wb_from_mem_i;
            rs1_data_o    <= rs1_data_i;
            rs2_data_o    <= rs2_data_i;
        end
    end

    assign rf_we_o = rf_we_q & (rf_waddr_o != '0); // x0 is never written

endmodule

// File: source/ex_operand_gen.sv
`timescale 1ns/1ps
`include "rv_ex_defines.svh"

module ex_operand_gen (
    input  logic [`RV_ILEN-1:0]     inst_i,
    input  logic [`RV_XLEN-1:0]     pc_i,
    input  logic [`RV_XLEN-1:0]     rs1_data_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    input  rv_ex_pkg::src1_sel_e    src1_sel_i,
    input  rv_ex_pkg::src2_sel_e    src2_sel_i,
    output logic [`RV_XLEN-1:0]     alu_src1_o,
    output logic [`RV_XLEN-1:0]     alu_src2_o,
    output logic [`RV_XLEN-1:0]     imm_i_o,
    output logic [`RV_XLEN-1:0]     imm_b_o,
    output logic [`RV_XLEN-1:0]     imm_j_o
);

    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] shamt_ext;

    // inst[31] is the sign bit of every format
    assign imm_i_o = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s   = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_o = {{(`RV_XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                      inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_o = {{(`RV_XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                      inst_i[20], inst_i[30:21], 1'b0};

    // upper immediate, already shifted by 12
    assign imm_u = {{(`RV_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    // 6-bit shamt for slli/srli/srai
    assign shamt_ext = {{(`RV_XLEN-`RV_SHAMT_W){1'b0}}, inst_i[20 +: `RV_SHAMT_W]};

    always_comb begin
        case (src1_sel_i)
            rv_ex_pkg::src1_pc:   alu_src1_o = pc_i;   // auipc, jal link
            rv_ex_pkg::src1_zero: alu_src1_o = '0;     // lui
            default:              alu_src1_o = rs1_data_i;
        endcase
    end

    always_comb begin
        case (src2_sel_i)
            rv_ex_pkg::src2_imm_i: alu_src2_o = imm_i_o;
            rv_ex_pkg::src2_imm_u: alu_src2_o = imm_u;
            rv_ex_pkg::src2_shamt: alu_src2_o = shamt_ext;
            rv_ex_pkg::src2_four:  alu_src2_o = `RV_XLEN'(`RV_LINK_OFS); // link value
            rv_ex_pkg::src2_imm_s: alu_src2_o = imm_s;  // store address
            default:               alu_src2_o = rs2_data_i;
        endcase
    end

endmodule

// File: source/ex_alu.sv
`timescale 1ns/1ps
`include "rv_ex_defines.svh"

module ex_alu (
    input  rv_ex_pkg::alu_op_e      alu_op_i,
    input  logic                    word_op_i,
    input  logic [`RV_XLEN-1:0]     src1_i,
    input  logic [`RV_XLEN-1:0]     src2_i,
    output logic [`RV_XLEN-1:0]     result_o
);

    localparam int WORD_W = `RV_XLEN / 2;

    logic [`RV_XLEN-1:0]     res_d;
    logic [WORD_W-1:0]       res_w;
    logic [WORD_W-1:0]       a_w;
    logic [WORD_W-1:0]       b_w;
    logic [`RV_SHAMT_W-1:0]  shamt_d;
    logic [`RV_WSHAMT_W-1:0] shamt_w;

    assign a_w     = src1_i[WORD_W-1:0];
    assign b_w     = src2_i[WORD_W-1:0];
    assign shamt_d = src2_i[`RV_SHAMT_W-1:0];
    assign shamt_w = src2_i[`RV_WSHAMT_W-1:0];

    // full width path
    always_comb begin
        case (alu_op_i)
            rv_ex_pkg::sub:    res_d = src1_i - src2_i;
            rv_ex_pkg::sll:    res_d = src1_i << shamt_d;
            rv_ex_pkg::slt:    res_d = {{(`RV_XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
            rv_ex_pkg::sltu:   res_d = {{(`RV_XLEN-1){1'b0}}, src1_i < src2_i};
            rv_ex_pkg::xor_op: res_d = src1_i ^ src2_i;
            rv_ex_pkg::srl:    res_d = src1_i >> shamt_d;
            rv_ex_pkg::sra:    res_d = $signed(src1_i) >>> shamt_d;
            rv_ex_pkg::or_op:  res_d = src1_i | src2_i;
            rv_ex_pkg::and_op: res_d = src1_i & src2_i;
            default:           res_d = src1_i + src2_i;
        endcase
    end

    // word path, low halves only
    always_comb begin
        case (alu_op_i)
            rv_ex_pkg::sub:    res_w = a_w - b_w;
            rv_ex_pkg::sll:    res_w = a_w << shamt_w;
            rv_ex_pkg::slt:    res_w = {{(WORD_W-1){1'b0}}, $signed(a_w) < $signed(b_w)};
            rv_ex_pkg::sltu:   res_w = {{(WORD_W-1){1'b0}}, a_w < b_w};
            rv_ex_pkg::xor_op: res_w = a_w ^ b_w;
            rv_ex_pkg::srl:    res_w = a_w >> shamt_w;
            rv_ex_pkg::sra:    res_w = $signed(a_w) >>> shamt_w;  // sraw
            rv_ex_pkg::or_op:  res_w = a_w | b_w;
            rv_ex_pkg::and_op: res_w = a_w & b_w;
            default:           res_w = a_w + b_w;
        endcase
    end

    // word results are sign-extended from bit 31
    assign result_o = word_op_i ? {{WORD_W{res_w[WORD_W-1]}}, res_w} : res_d;

endmodule

// File: source/ex_branch_unit.sv
`timescale 1ns/1ps
`include "rv_ex_defines.svh"

module ex_branch_unit (
    input  rv_ex_pkg::bru_op_e      bru_op_i,
    input  logic [`RV_XLEN-1:0]     pc_i,
    input  logic [`RV_XLEN-1:0]     next_pc_i,
    input  logic [`RV_XLEN-1:0]     rs1_data_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    input  logic [`RV_XLEN-1:0]     imm_i_i,
    input  logic [`RV_XLEN-1:0]     imm_b_i,
    input  logic [`RV_XLEN-1:0]     imm_j_i,
    output logic                    br_taken_o,
    output logic [`RV_XLEN-1:0]     br_target_o,
    output logic [`RV_XLEN-1:0]     real_npc_o
);

    logic                eq;
    logic                lt_s;
    logic                lt_u;
    logic [`RV_XLEN-1:0] b_target;
    logic [`RV_XLEN-1:0] jr_sum;

    assign eq       = (rs1_data_i == rs2_data_i);
    assign lt_s     = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign lt_u     = (rs1_data_i < rs2_data_i);
    assign b_target = pc_i + imm_b_i;
    assign jr_sum   = rs1_data_i + imm_i_i;

    always_comb begin
        case (bru_op_i)
            rv_ex_pkg::jal,
            rv_ex_pkg::jalr: br_taken_o = 1'b1;   // jumps always redirect
            rv_ex_pkg::beq:  br_taken_o = eq;
            rv_ex_pkg::bne:  br_taken_o = !eq;
            rv_ex_pkg::blt:  br_taken_o = lt_s;
            rv_ex_pkg::bge:  br_taken_o = !lt_s;
            rv_ex_pkg::bltu: br_taken_o = lt_u;
            rv_ex_pkg::bgeu: br_taken_o = !lt_u;
            default:         br_taken_o = 1'b0;
        endcase
    end

    always_comb begin
        case (bru_op_i)
            rv_ex_pkg::jal:  br_target_o = pc_i + imm_j_i;
            rv_ex_pkg::jalr: br_target_o = {jr_sum[`RV_XLEN-1:1], 1'b0};
            rv_ex_pkg::beq, rv_ex_pkg::bne, rv_ex_pkg::blt,
            rv_ex_pkg::bge, rv_ex_pkg::bltu, rv_ex_pkg::bgeu: br_target_o = b_target;
            default:         br_target_o = '0;   // bru_none
        endcase
    end

    assign real_npc_o = br_taken_o ? br_target_o : next_pc_i; // corrected fetch pc

endmodule

// File: source/ex_store_format.sv
`timescale 1ns/1ps
`include "rv_ex_defines.svh"

module ex_store_format (
    input  rv_ex_pkg::lsu_size_e    lsu_size_i,
    input  logic [`RV_XLEN-1:0]     addr_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    output logic [`RV_XLEN-1:0]     wdata_o,
    output logic [`RV_STRB_W-1:0]   sel_o
);

    logic [2:0] ofs;    // byte offset in the double word

    assign ofs = addr_i[2:0];

    // replicate the store payload into every lane of its size
    always_comb begin
        case (lsu_size_i)
            rv_ex_pkg::lsu_b: wdata_o = {8{rs2_data_i[7:0]}};
            rv_ex_pkg::lsu_h: wdata_o = {4{rs2_data_i[15:0]}};
            rv_ex_pkg::lsu_w: wdata_o = {2{rs2_data_i[31:0]}};
            rv_ex_pkg::lsu_d: wdata_o = rs2_data_i;
            default:          wdata_o = '0;
        endcase
    end

    always_comb begin
        case (lsu_size_i)
            rv_ex_pkg::lsu_b: sel_o = `RV_STRB_W'(1) << ofs;
            rv_ex_pkg::lsu_h: sel_o = `RV_STRB_W'(2'b11) << {ofs[2:1], 1'b0};
            rv_ex_pkg::lsu_w: sel_o = ofs[2] ? `RV_STRB_W'(8'hf0) : `RV_STRB_W'(8'h0f);
            rv_ex_pkg::lsu_d: sel_o = '1;
            default:          sel_o = '0;
        endcase
    end

endmodule

// File: source/rv_ex_top.sv
`timescale 1ns/1ps
`include "rv_ex_defines.svh"

module rv_ex_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic [`RV_XLEN-1:0]     pc_i,
    input  logic [`RV_XLEN-1:0]     next_pc_i,
    input  logic [`RV_ILEN-1:0]     inst_i,
    input  rv_ex_pkg::alu_op_e      alu_op_i,
    input  logic                    word_op_i,
    input  rv_ex_pkg::src1_sel_e    src1_sel_i,
    input  rv_ex_pkg::src2_sel_e    src2_sel_i,
    input  rv_ex_pkg::bru_op_e      bru_op_i,
    input  rv_ex_pkg::lsu_size_e    lsu_size_i,
    input  logic                    dmem_en_i,
    input  logic                    dmem_we_i,
    input  logic                    rf_we_i,
    input  logic [`RV_REG_AW-1:0]   rf_waddr_i,
    input  logic                    wb_from_mem_i,
    input  logic [`RV_XLEN-1:0]     rs1_data_i,
    input  logic [`RV_XLEN-1:0]     rs2_data_i,
    output logic [`RV_XLEN-1:0]     ex_pc_o,
    output logic [`RV_XLEN-1:0]     ex_result_o,
    output logic [`RV_XLEN-1:0]     real_npc_o,
    output logic                    br_taken_o,
    output logic [`RV_XLEN-1:0]     br_target_o,
    output logic                    dmem_en_o,
    output logic                    dmem_we_o,
    output logic [`RV_XLEN-1:0]     dmem_addr_o,
    output logic [`RV_XLEN-1:0]     dmem_wdata_o,
    output logic [`RV_STRB_W-1:0]   dmem_sel_o,
    output logic                    rf_we_o,
    output logic [`RV_REG_AW-1:0]   rf_waddr_o,
    output logic                    wb_from_mem_o
);

    logic [`RV_XLEN-1:0]  ex_next_pc;
    logic [`RV_ILEN-1:0]  ex_inst;
    rv_ex_pkg::alu_op_e   ex_alu_op;
    logic                 ex_word_op;
    rv_ex_pkg::src1_sel_e ex_src1_sel;
    rv_ex_pkg::src2_sel_e ex_src2_sel;
    rv_ex_pkg::bru_op_e   ex_bru_op;
    rv_ex_pkg::lsu_size_e ex_lsu_size;
    logic [`RV_XLEN-1:0]  ex_rs1_data;
    logic [`RV_XLEN-1:0]  ex_rs2_data;
    logic [`RV_XLEN-1:0]  alu_src1;
    logic [`RV_XLEN-1:0]  alu_src2;
    logic [`RV_XLEN-1:0]  imm_i;
    logic [`RV_XLEN-1:0]  imm_b;
    logic [`RV_XLEN-1:0]  imm_j;
    logic [`RV_XLEN-1:0]  alu_result;

    ex_stage_reg u_stage_reg (
        .clk(clk), .rst(rst), .stall_i(stall_i), .flush_i(flush_i),
        .pc_i(pc_i), .next_pc_i(next_pc_i), .inst_i(inst_i),
        .alu_op_i(alu_op_i), .word_op_i(word_op_i),
        .src1_sel_i(src1_sel_i), .src2_sel_i(src2_sel_i),
        .bru_op_i(bru_op_i), .lsu_size_i(lsu_size_i),
        .dmem_en_i(dmem_en_i), .dmem_we_i(dmem_we_i),
        .rf_we_i(rf_we_i), .rf_waddr_i(rf_waddr_i), .wb_from_mem_i(wb_from_mem_i),
        .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
        .pc_o(ex_pc_o), .next_pc_o(ex_next_pc), .inst_o(ex_inst),
        .alu_op_o(ex_alu_op), .word_op_o(ex_word_op),
        .src1_sel_o(ex_src1_sel), .src2_sel_o(ex_src2_sel),
        .bru_op_o(ex_bru_op), .lsu_size_o(ex_lsu_size),
        .dmem_en_o(dmem_en_o), .dmem_we_o(dmem_we_o),
        .rf_we_o(rf_we_o), .rf_waddr_o(rf_waddr_o), .wb_from_mem_o(wb_from_mem_o),
        .rs1_data_o(ex_rs1_data), .rs2_data_o(ex_rs2_data)
    );

    ex_operand_gen u_operand_gen (
        .inst_i(ex_inst), .pc_i(ex_pc_o),
        .rs1_data_i(ex_rs1_data), .rs2_data_i(ex_rs2_data),
        .src1_sel_i(ex_src1_sel), .src2_sel_i(ex_src2_sel),
        .alu_src1_o(alu_src1), .alu_src2_o(alu_src2),
        .imm_i_o(imm_i), .imm_b_o(imm_b), .imm_j_o(imm_j)
    );

    ex_alu u_alu (
        .alu_op_i(ex_alu_op), .word_op_i(ex_word_op),
        .src1_i(alu_src1), .src2_i(alu_src2), .result_o(alu_result)
    );

    ex_branch_unit u_branch_unit (
        .bru_op_i(ex_bru_op), .pc_i(ex_pc_o), .next_pc_i(ex_next_pc),
        .rs1_data_i(ex_rs1_data), .rs2_data_i(ex_rs2_data),
        .imm_i_i(imm_i), .imm_b_i(imm_b), .imm_j_i(imm_j),
        .br_taken_o(br_taken_o), .br_target_o(br_target_o), .real_npc_o(real_npc_o)
    );

    // alu sum doubles as the data memory address
    ex_store_format u_store_format (
        .lsu_size_i(ex_lsu_size), .addr_i(alu_result), .rs2_data_i(ex_rs2_data),
        .wdata_o(dmem_wdata_o), .sel_o(dmem_sel_o)
    );

    assign ex_result_o = alu_result;
    assign dmem_addr_o = alu_result;

endmodule

// File: tb/rv_ex_props.sv
`timescale 1ns/1ps
`include "rv_ex_defines.svh"

module rv_ex_props (
    input logic                clk,
    input logic                rst,
    input logic                stall_i,
    input logic                flush_i,
    input logic                rf_we_o,
    input logic                dmem_en_o,
    input logic                br_taken_o,
    input logic [`RV_XLEN-1:0] ex_pc_o,
    input logic [`RV_XLEN-1:0] br_target_o
);

    // a cleared stage register must look like a bubble
    bubble_after_clear: assert property (@(posedge clk)
        (rst || flush_i) |=> (!rf_we_o && !dmem_en_o && !br_taken_o))
        else $error("control output active one cycle after reset or flush");

    pc_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        (stall_i && !flush_i) |=> $stable(ex_pc_o))
        else $error("ex_pc_o changed across a stall");

    // every redirect target is at least halfword aligned
    target_aligned: assert property (@(posedge clk)
        (br_taken_o && ex_pc_o[1:0] == 2'b00) |-> !br_target_o[0])
        else $error("branch target has bit 0 set");

endmodule

bind rv_ex_top rv_ex_props u_props (
    .clk(clk), .rst(rst), .stall_i(stall_i), .flush_i(flush_i),
    .rf_we_o(rf_we_o), .dmem_en_o(dmem_en_o), .br_taken_o(br_taken_o),
    .ex_pc_o(ex_pc_o), .br_target_o(br_target_o)
);

// File: tb/rv_ex_tb.sv
`timescale 1ns/1ps
`include "rv_ex_defines.svh"

module rv_ex_tb;

    localparam int ALU_REPS    = 4;
    localparam int NUM_VECTORS = 4 + 10 * 2 * ALU_REPS + 8 + 16 + 16 + 5;

    localparam logic [63:0] S_MIN = 64'h8000_0000_0000_0000;
    localparam logic [63:0] S_MAX = 64'h7fff_ffff_ffff_ffff;
    localparam logic [63:0] ALL1  = 64'hffff_ffff_ffff_ffff;

    // imm_i and imm_j are 32 and imm_b is 48 in the branch test instruction
    localparam logic [31:0] BR_INST = 32'h0200_0800;
    localparam logic [63:0] BR_PC   = 64'h0000_0000_0000_4000;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    stall_i;
    logic                    flush_i;
    logic [`RV_XLEN-1:0]     pc_i;
    logic [`RV_XLEN-1:0]     next_pc_i;
    logic [`RV_ILEN-1:0]     inst_i;
    rv_ex_pkg::alu_op_e      alu_op_i;
    logic                    word_op_i;
    rv_ex_pkg::src1_sel_e    src1_sel_i;
    rv_ex_pkg::src2_sel_e    src2_sel_i;
    rv_ex_pkg::bru_op_e      bru_op_i;
    rv_ex_pkg::lsu_size_e    lsu_size_i;
    logic                    dmem_en_i;
    logic                    dmem_we_i;
    logic                    rf_we_i;
    logic [`RV_REG_AW-1:0]   rf_waddr_i;
    logic                    wb_from_mem_i;
    logic [`RV_XLEN-1:0]     rs1_data_i;
    logic [`RV_XLEN-1:0]     rs2_data_i;
    logic [`RV_XLEN-1:0]     ex_pc_o;
    logic [`RV_XLEN-1:0]     ex_result_o;
    logic [`RV_XLEN-1:0]     real_npc_o;
    logic                    br_taken_o;
    logic [`RV_XLEN-1:0]     br_target_o;
    logic                    dmem_en_o;
    logic                    dmem_we_o;
    logic [`RV_XLEN-1:0]     dmem_addr_o;
    logic [`RV_XLEN-1:0]     dmem_wdata_o;
    logic [`RV_STRB_W-1:0]   dmem_sel_o;
    logic                    rf_we_o;
    logic [`RV_REG_AW-1:0]   rf_waddr_o;
    logic                    wb_from_mem_o;

    integer seed;
    int     errors;
    int     checks;

    rv_ex_top DUT (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    // watchdog sized from the vector count
    initial begin
        #(NUM_VECTORS * 40 + 1000);
        $display("timeout: the tests did not finish in the expected time");
        $display("Result: FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: got 0x%0h expected 0x%0h", name, act, exp);
        end
    endtask

    task automatic step();
        @(negedge clk);  // one rising edge in between
    endtask

    task automatic test_done(input string name, input int errs_before);
        if (errors == errs_before)
            $display("%s done, no errors", name);
        else
            $display("%s done, %0d errors", name, errors - errs_before);
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic set_nop();
        pc_i          = '0;
        next_pc_i     = '0;
        inst_i        = '0;
        alu_op_i      = rv_ex_pkg::add;
        word_op_i     = 1'b0;
        src1_sel_i    = rv_ex_pkg::src1_rs1;
        src2_sel_i    = rv_ex_pkg::src2_rs2;
        bru_op_i      = rv_ex_pkg::bru_none;
        lsu_size_i    = rv_ex_pkg::lsu_none;
        dmem_en_i     = 1'b0;
        dmem_we_i     = 1'b0;
        rf_we_i       = 1'b0;
        rf_waddr_i    = '0;
        wb_from_mem_i = 1'b0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
    endtask

    task automatic check_bubble();
        check("rf_we_o", rf_we_o, 0);
        check("dmem_en_o", dmem_en_o, 0);
        check("dmem_we_o", dmem_we_o, 0);
        check("br_taken_o", br_taken_o, 0);
        check("dmem_sel_o", dmem_sel_o, 0);
        check("rf_waddr_o", rf_waddr_o, 0);
        check("wb_from_mem_o", wb_from_mem_o, 0);
    endtask

    // reference alu built from the RV64I rules
    function automatic logic [63:0] alu_expect(input rv_ex_pkg::alu_op_e op, input logic word,
                                               input logic [63:0] a, input logic [63:0] b);
        logic [31:0] aw;
        logic [31:0] bw;
        logic [31:0] rw;
        logic [63:0] r;
        aw = a[31:0];
        bw = b[31:0];
        rw = '0;
        r  = '0;
        if (!word) begin
            case (op)
                rv_ex_pkg::add:    r = a + b;
                rv_ex_pkg::sub:    r = a - b;
                rv_ex_pkg::sll:    r = a << b[5:0];
                rv_ex_pkg::slt:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                rv_ex_pkg::sltu:   r = (a < b) ? 64'd1 : 64'd0;
                rv_ex_pkg::xor_op: r = a ^ b;
                rv_ex_pkg::srl:    r = a >> b[5:0];
                rv_ex_pkg::sra:    r = $signed(a) >>> b[5:0];
                rv_ex_pkg::or_op:  r = a | b;
                rv_ex_pkg::and_op: r = a & b;
                default:           r = 'x;
            endcase
            return r;
        end
        case (op)
            rv_ex_pkg::add:    rw = aw + bw;
            rv_ex_pkg::sub:    rw = aw - bw;
            rv_ex_pkg::sll:    rw = aw << bw[4:0];
            rv_ex_pkg::slt:    rw = ($signed(aw) < $signed(bw)) ? 32'd1 : 32'd0;
            rv_ex_pkg::sltu:   rw = (aw < bw) ? 32'd1 : 32'd0;
            rv_ex_pkg::xor_op: rw = aw ^ bw;
            rv_ex_pkg::srl:    rw = aw >> bw[4:0];
            rv_ex_pkg::sra:    rw = $signed(aw) >>> bw[4:0];
            rv_ex_pkg::or_op:  rw = aw | bw;
            rv_ex_pkg::and_op: rw = aw & bw;
            default:           rw = 'x;
        endcase
        return {{32{rw[31]}}, rw};
    endfunction

    task automatic test_reset();
        int e0;
        e0 = errors;
        // active inputs so a missing clear would show up
        rf_we_i       = 1'b1;
        rf_waddr_i    = 5'd5;
        wb_from_mem_i = 1'b1;
        dmem_en_i     = 1'b1;
        dmem_we_i     = 1'b1;
        bru_op_i      = rv_ex_pkg::jal;
        lsu_size_i    = rv_ex_pkg::lsu_d;
        repeat (3) begin
            step();
            check_bubble();
        end
        rst = 1'b0;
        test_done("reset", e0);
    endtask

    task automatic test_alu();
        int          e0;
        logic [31:0] rnd;
        e0 = errors;
        for (int k = 0; k < 10; k++) begin
            for (int w = 0; w < 2; w++) begin
                for (int rep = 0; rep < ALU_REPS; rep++) begin
                    set_nop();
                    rnd           = $random(seed);
                    alu_op_i      = rv_ex_pkg::alu_op_e'(k);
                    word_op_i     = w[0];
                    rs1_data_i    = rand64();
                    rs2_data_i    = rand64();
                    rf_we_i       = (rep == 0) ? 1'b1 : rnd[0];
                    rf_waddr_i    = (rep == 0) ? 5'd0 : rnd[8:4];
                    wb_from_mem_i = rnd[1];
                    step();
                    check("ex_result_o", ex_result_o,
                          alu_expect(alu_op_i, word_op_i, rs1_data_i, rs2_data_i));
                    check("rf_we_o", rf_we_o, rf_we_i && (rf_waddr_i != 0));
                    check("rf_waddr_o", rf_waddr_o, rf_waddr_i);
                    check("wb_from_mem_o", wb_from_mem_o, wb_from_mem_i);
                end
            end
        end
        test_done("alu", e0);
    endtask

    task automatic operand_case(input string what, input rv_ex_pkg::src1_sel_e s1,
                                input rv_ex_pkg::src2_sel_e s2, input rv_ex_pkg::alu_op_e op,
                                input logic [31:0] inst, input logic [63:0] pc,
                                input logic [63:0] rs1, input logic [63:0] exp);
        set_nop();
        src1_sel_i = s1;
        src2_sel_i = s2;
        alu_op_i   = op;
        inst_i     = inst;
        pc_i       = pc;
        rs1_data_i = rs1;
        rs2_data_i = rand64();   // must not leak into the result
        step();
        check({"ex_result_o ", what}, ex_result_o, exp);
    endtask

    task automatic test_operands();
        int e0;
        e0 = errors;
        operand_case("lui", rv_ex_pkg::src1_zero, rv_ex_pkg::src2_imm_u, rv_ex_pkg::add,
                     32'habcd_e037, 64'h40, 64'h5, 64'hffff_ffff_abcd_e000);
        operand_case("auipc", rv_ex_pkg::src1_pc, rv_ex_pkg::src2_imm_u, rv_ex_pkg::add,
                     32'h1234_5017, 64'h1000, 64'h0, 64'h1234_6000);
        operand_case("link", rv_ex_pkg::src1_pc, rv_ex_pkg::src2_four, rv_ex_pkg::add,
                     32'h0, 64'h2000_0000_0040, 64'h0, 64'h2000_0000_0044);
        operand_case("addi -5", rv_ex_pkg::src1_rs1, rv_ex_pkg::src2_imm_i, rv_ex_pkg::add,
                     32'hffb0_0013, 64'h0, 64'd100, 64'd95);
        operand_case("addi -2048", rv_ex_pkg::src1_rs1, rv_ex_pkg::src2_imm_i, rv_ex_pkg::add,
                     32'h8000_0013, 64'h0, 64'h0, 64'hffff_ffff_ffff_f800);
        operand_case("slli 40", rv_ex_pkg::src1_rs1, rv_ex_pkg::src2_shamt, rv_ex_pkg::sll,
                     32'h0280_1013, 64'h0, 64'h1, 64'h0000_0100_0000_0000);
        operand_case("srai 33", rv_ex_pkg::src1_rs1, rv_ex_pkg::src2_shamt, rv_ex_pkg::sra,
                     32'h4210_5013, 64'h0, S_MIN, 64'hffff_ffff_c000_0000);
        operand_case("store addr", rv_ex_pkg::src1_rs1, rv_ex_pkg::src2_imm_s, rv_ex_pkg::add,
                     32'hfe00_0c23, 64'h0, 64'h1000, 64'h0ff8);
        test_done("operands", e0);
    endtask

    task automatic branch_case(input rv_ex_pkg::bru_op_e op, input logic [63:0] a,
                               input logic [63:0] b, input logic taken);
        logic [63:0] target;
        set_nop();
        bru_op_i   = op;
        inst_i     = BR_INST;
        pc_i       = BR_PC;
        next_pc_i  = BR_PC + 64'd4;
        rs1_data_i = a;
        rs2_data_i = b;
        case (op)
            rv_ex_pkg::bru_none: target = '0;
            rv_ex_pkg::jal:      target = BR_PC + 64'd32;
            rv_ex_pkg::jalr:     target = (a + 64'd32) & ~64'd1;
            default:             target = BR_PC + 64'd48;
        endcase
        step();
        check("br_taken_o", br_taken_o, taken);
        check("br_target_o", br_target_o, target);
        check("real_npc_o", real_npc_o, taken ? target : BR_PC + 64'd4);
    endtask

    task automatic test_branches();
        int e0;
        e0 = errors;
        branch_case(rv_ex_pkg::beq, 64'd5, 64'd5, 1'b1);
        branch_case(rv_ex_pkg::beq, 64'd5, 64'd6, 1'b0);
        branch_case(rv_ex_pkg::bne, 64'd5, 64'd6, 1'b1);
        branch_case(rv_ex_pkg::bne, 64'd7, 64'd7, 1'b0);
        branch_case(rv_ex_pkg::blt, ALL1, 64'd0, 1'b1);    // -1 < 0 signed
        branch_case(rv_ex_pkg::blt, 64'd0, ALL1, 1'b0);
        branch_case(rv_ex_pkg::bge, S_MIN, S_MAX, 1'b0);
        branch_case(rv_ex_pkg::bge, S_MAX, S_MIN, 1'b1);
        branch_case(rv_ex_pkg::bge, 64'd3, 64'd3, 1'b1);
        branch_case(rv_ex_pkg::bltu, 64'd0, ALL1, 1'b1);
        branch_case(rv_ex_pkg::bltu, ALL1, 64'd0, 1'b0);
        branch_case(rv_ex_pkg::bgeu, ALL1, 64'd0, 1'b1);
        branch_case(rv_ex_pkg::bgeu, 64'd0, 64'd1, 1'b0);
        branch_case(rv_ex_pkg::jal, 64'd0, 64'd0, 1'b1);
        branch_case(rv_ex_pkg::jalr, 64'h1001, 64'd0, 1'b1);  // bit 0 of the odd sum is dropped
        branch_case(rv_ex_pkg::bru_none, 64'd5, 64'd5, 1'b0);
        test_done("branches", e0);
    endtask

    // size 0 stands for no access
    task automatic store_case(input int sz, input int ofs);
        int          nbytes;
        logic [63:0] wdata;
        logic [15:0] mask;
        nbytes = (sz == 0) ? 0 : (1 << (sz - 1));
        set_nop();
        lsu_size_i = rv_ex_pkg::lsu_size_e'(sz);
        dmem_en_i  = (sz != 0);
        dmem_we_i  = (sz != 0);
        src2_sel_i = rv_ex_pkg::src2_imm_s;   // inst 0 gives a zero offset
        rs1_data_i = 64'h8000_1000 + ofs;
        rs2_data_i = rand64();
        wdata      = '0;
        mask       = '0;
        if (nbytes != 0) begin
            for (int k = 0; k < 8; k++)
                wdata[8*k +: 8] = rs2_data_i[8*(k % nbytes) +: 8];
            mask = ((16'd1 << nbytes) - 16'd1) << ofs;
        end
        step();
        check("dmem_addr_o", dmem_addr_o, rs1_data_i);
        check("dmem_wdata_o", dmem_wdata_o, wdata);
        check("dmem_sel_o", dmem_sel_o, mask[7:0]);
        check("dmem_en_o", dmem_en_o, dmem_en_i);
        check("dmem_we_o", dmem_we_o, dmem_we_i);
    endtask

    task automatic test_stores();
        int e0;
        e0 = errors;
        for (int sz = 1; sz <= 4; sz++) begin
            for (int ofs = 0; ofs < 8; ofs += (1 << (sz - 1)))
                store_case(sz, ofs);
        end
        store_case(0, 0);
        test_done("stores", e0);
    endtask

    task automatic test_stall_flush();
        int e0;
        e0 = errors;
        set_nop();
        pc_i       = 64'h100;
        rs1_data_i = 64'd10;
        rs2_data_i = 64'd20;
        rf_we_i    = 1'b1;
        rf_waddr_i = 5'd3;
        bru_op_i   = rv_ex_pkg::jal;
        step();
        check("ex_pc_o", ex_pc_o, 64'h100);
        check("ex_result_o", ex_result_o, 64'd30);
        // new instruction shows up while held
        pc_i       = 64'h200;
        rs1_data_i = 64'd1;
        rs2_data_i = 64'd1;
        rf_we_i    = 1'b0;
        bru_op_i   = rv_ex_pkg::bru_none;
        stall_i    = 1'b1;
        repeat (2) begin
            step();
            check("ex_pc_o", ex_pc_o, 64'h100);
            check("ex_result_o", ex_result_o, 64'd30);
            check("rf_we_o", rf_we_o, 1'b1);
            check("br_taken_o", br_taken_o, 1'b1);
        end
        flush_i = 1'b1;   // flush beats the stall
        step();
        check_bubble();
        check("ex_pc_o", ex_pc_o, 64'h0);
        stall_i = 1'b0;
        flush_i = 1'b0;
        step();
        check("ex_pc_o", ex_pc_o, 64'h200);
        check("ex_result_o", ex_result_o, 64'd2);
        check("rf_we_o", rf_we_o, 1'b0);
        check("br_taken_o", br_taken_o, 1'b0);
        test_done("stall and flush", e0);
    endtask

    initial begin
        seed    = 56275;
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        stall_i = 1'b0;
        flush_i = 1'b0;
        set_nop();
        test_reset();
        test_alu();
        test_operands();
        test_branches();
        test_stores();
        test_stall_flush();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: rv_ex_top.f
+incdir+source
source/rv_ex_pkg.sv
source/ex_stage_reg.sv
source/ex_operand_gen.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_store_format.sv
source/rv_ex_top.sv
tb/rv_ex_props.sv
tb/rv_ex_tb.sv
